// ==== design/vga_pattern.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_pattern #(
  parameter int BAR_SHIFT   = 7,  // log2 of bar width.
  parameter int CHECK_SHIFT = 5   // log2 of checker square.
) (
  vga_scan_if.source             scan,
  input  vga_pkg::pat_mode_e     i_mode,
  input  vga_pkg::rgb_t          i_fg,
  input  vga_pkg::rgb_t          i_box_bg,
  input  logic [vga_pkg::X_W-1:0] i_box_x,
  input  logic [vga_pkg::X_W-1:0] i_box_y,
  input  logic [vga_pkg::X_W-1:0] i_box_size
);

  import vga_pkg::*;

  logic [2:0]   bar_idx;      // which of eight bars.
  rgb_t         bar_color;
  logic         check_odd;    // odd square of the board.
  rgb_t         check_color;
  logic [X_W:0] x_ext;        // one spare bit so box edges never wrap.
  logic [X_W:0] y_ext;
  logic [X_W:0] box_x_lo;
  logic [X_W:0] box_y_lo;
  logic [X_W:0] box_x_end;
  logic [X_W:0] box_y_end;
  logic         in_box_x;
  logic         in_box_y;
  rgb_t         box_color;
  rgb_t         pat_color;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // color bars
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign bar_idx     = 3'(scan.x >> BAR_SHIFT);  // wraps every eight bars.
  assign bar_color.r = bar_idx[2] ? 4'hF : 4'h0;
  assign bar_color.g = bar_idx[1] ? 4'hF : 4'h0;
  assign bar_color.b = bar_idx[0] ? 4'hF : 4'h0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checkerboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign check_odd   = scan.x[CHECK_SHIFT] ^ scan.y[CHECK_SHIFT];
  assign check_color = check_odd ? ~i_fg : i_fg;  // complement on odd squares.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // box
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign x_ext     = {1'b0, scan.x};
  assign y_ext     = (X_W + 1)'(scan.y);    // zero extend the line.
  assign box_x_lo  = {1'b0, i_box_x};
  assign box_y_lo  = {1'b0, i_box_y};
  assign box_x_end = box_x_lo + {1'b0, i_box_size};  // exclusive edge.
  assign box_y_end = box_y_lo + {1'b0, i_box_size};

  assign in_box_x  = (x_ext >= box_x_lo) && (x_ext < box_x_end);
  assign in_box_y  = (y_ext >= box_y_lo) && (y_ext < box_y_end);
  assign box_color = (in_box_x && in_box_y) ? i_fg : i_box_bg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mode select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (i_mode)
      PAT_SOLID:   pat_color = i_fg;
      PAT_BARS:    pat_color = bar_color;
      PAT_CHECKER: pat_color = check_color;
      PAT_BOX:     pat_color = box_color;
      default:     pat_color = i_fg;
    endcase
  end

  // nothing to show off screen, keep the bus quiet.
  assign scan.color = scan.active ? pat_color : '0;

endmodule

`default_nettype wire

// ==== design/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int X_W        = 11;  // column counter and x coordinate.
  localparam int Y_W        = 10;  // line counter and y coordinate.
  localparam int REG_ADDR_W = 3;   // register address.
  localparam int REG_DATA_W = 16;  // register write data.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [REG_ADDR_W-1:0] ADDR_MODE     = 3'd0;  // pattern select.
  localparam logic [REG_ADDR_W-1:0] ADDR_FG       = 3'd1;  // foreground color.
  localparam logic [REG_ADDR_W-1:0] ADDR_BOX_BG   = 3'd2;  // color around the box.
  localparam logic [REG_ADDR_W-1:0] ADDR_BOX_X    = 3'd3;  // box left edge.
  localparam logic [REG_ADDR_W-1:0] ADDR_BOX_Y    = 3'd4;  // box top edge.
  localparam logic [REG_ADDR_W-1:0] ADDR_BOX_SIZE = 3'd5;  // box side, 6 and 7 unmapped.

  typedef enum logic [1:0] {
    PAT_SOLID   = 2'd0,  // flat foreground.
    PAT_BARS    = 2'd1,  // eight vertical bars.
    PAT_CHECKER = 2'd2,  // fg and inverted fg squares.
    PAT_BOX     = 2'd3   // square over box background.
  } pat_mode_e;

  typedef struct packed {
    logic [3:0] r;  // red.
    logic [3:0] g;  // green.
    logic [3:0] b;  // blue.
  } rgb_t;

  // one write word, read as a color or as a coordinate depending on address.
  typedef union packed {
    struct packed {
      logic [REG_DATA_W-$bits(rgb_t)-1:0] spare;  // ignored.
      rgb_t                               color;  // fg and box bg.
    } col;
    struct packed {
      logic [REG_DATA_W-X_W-1:0] spare;  // ignored.
      logic [X_W-1:0]            value;  // box x, y and size.
    } crd;
  } reg_word_u;

endpackage

`default_nettype wire

// ==== design/vga_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_regs (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_wr_en,     // single-cycle strobe.
  input  logic [vga_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  vga_pkg::reg_word_u             i_wr_data,
  output vga_pkg::pat_mode_e             o_mode,
  output vga_pkg::rgb_t                  o_fg,
  output vga_pkg::rgb_t                  o_box_bg,
  output logic [vga_pkg::X_W-1:0]        o_box_x,
  output logic [vga_pkg::X_W-1:0]        o_box_y,
  output logic [vga_pkg::X_W-1:0]        o_box_size
);

  import vga_pkg::*;

  localparam rgb_t           FG_RST   = '{r: 4'hF, g: 4'hF, b: 4'hF};  // white.
  localparam rgb_t           BOX_RST  = '{r: 4'h0, g: 4'h0, b: 4'h0};  // black.
  localparam logic [X_W-1:0] SIZE_RST = X_W'(8);                       // 8x8 box.

  logic wr_mode;
  logic wr_fg;
  logic wr_box_bg;
  logic wr_box_x;
  logic wr_box_y;
  logic wr_box_size;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    wr_mode     = 1'b0;
    wr_fg       = 1'b0;
    wr_box_bg   = 1'b0;
    wr_box_x    = 1'b0;
    wr_box_y    = 1'b0;
    wr_box_size = 1'b0;
    if (i_wr_en) begin
      case (i_wr_addr)
        ADDR_MODE:     wr_mode     = 1'b1;
        ADDR_FG:       wr_fg       = 1'b1;
        ADDR_BOX_BG:   wr_box_bg   = 1'b1;
        ADDR_BOX_X:    wr_box_x    = 1'b1;
        ADDR_BOX_Y:    wr_box_y    = 1'b1;
        ADDR_BOX_SIZE: wr_box_size = 1'b1;
        default:       ;                    // 6 and 7 dropped.
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mode     <= PAT_SOLID;
      o_fg       <= FG_RST;
      o_box_bg   <= BOX_RST;
      o_box_x    <= '0;
      o_box_y    <= '0;
      o_box_size <= SIZE_RST;
    end else begin
      if (wr_mode) begin
        o_mode <= pat_mode_e'(i_wr_data.crd.value[1:0]);  // low two bits only.
      end
      if (wr_fg) begin
        o_fg <= i_wr_data.col.color;      // color view.
      end
      if (wr_box_bg) begin
        o_box_bg <= i_wr_data.col.color;
      end
      if (wr_box_x) begin
        o_box_x <= i_wr_data.crd.value;   // coordinate view.
      end
      if (wr_box_y) begin
        o_box_y <= i_wr_data.crd.value;
      end
      if (wr_box_size) begin
        o_box_size <= i_wr_data.crd.value;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/vga_scan_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface vga_scan_if;

  import vga_pkg::*;

  logic [X_W-1:0] x;            // column, relative to active start.
  logic [Y_W-1:0] y;            // line, relative to active start.
  logic           active;       // inside visible area.
  logic           frame_start;  // both counters at zero.
  rgb_t           color;        // pattern color for this pixel.

  // raster side owns the coordinates.
  modport timing (
    output x,
    output y,
    output active,
    output frame_start,
    input  color
  );

  // pattern side answers with a color.
  modport source (
    input  x,
    input  y,
    input  active,
    input  frame_start,
    output color
  );

endinterface

`default_nettype wire

// ==== design/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_timing #(
  parameter int            H_TOTAL        = 1680,
  parameter int            V_TOTAL        = 828,
  parameter int            H_SYNC_END     = 135,
  parameter int            V_SYNC_END     = 2,
  parameter int            H_ACTIVE_START = 336,   // first visible column.
  parameter int            H_ACTIVE_END   = 1615,  // last visible column.
  parameter int            V_ACTIVE_START = 27,    // first visible line.
  parameter int            V_ACTIVE_END   = 826,   // last visible line.
  parameter vga_pkg::rgb_t BG             = '{r: 4'h0, g: 4'h0, b: 4'h0}
) (
  input  logic          i_clk,
  input  logic          i_rst,
  vga_scan_if.timing    scan,
  output logic          o_hsync,
  output logic          o_vsync,
  output logic          o_de,
  output vga_pkg::rgb_t o_pix
);

  import vga_pkg::*;

  localparam logic [X_W-1:0] H_LAST   = X_W'(H_TOTAL - 1);
  localparam logic [Y_W-1:0] V_LAST   = Y_W'(V_TOTAL - 1);
  localparam logic [X_W-1:0] H_SYNC   = X_W'(H_SYNC_END);
  localparam logic [Y_W-1:0] V_SYNC   = Y_W'(V_SYNC_END);
  localparam logic [X_W-1:0] H_ACT_LO = X_W'(H_ACTIVE_START);
  localparam logic [X_W-1:0] H_ACT_HI = X_W'(H_ACTIVE_END);
  localparam logic [Y_W-1:0] V_ACT_LO = Y_W'(V_ACTIVE_START);
  localparam logic [Y_W-1:0] V_ACT_HI = Y_W'(V_ACTIVE_END);

  logic [X_W-1:0] hcount;  // pixel within line.
  logic [Y_W-1:0] vcount;  // line within frame.
  logic           h_wrap;
  logic           h_act;
  logic           v_act;
  logic           active;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // raster counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign h_wrap = (hcount == H_LAST);  // end of line.

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      hcount <= '0;
    end else if (h_wrap) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vcount <= '0;
    end else if (h_wrap) begin
      if (vcount == V_LAST) begin
        vcount <= '0;             // end of frame.
      end else begin
        vcount <= vcount + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sync and active area
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign o_hsync = (hcount > H_SYNC);  // low through the sync pulse.
  assign o_vsync = (vcount > V_SYNC);

  assign h_act  = (hcount >= H_ACT_LO) && (hcount <= H_ACT_HI);  // inclusive range.
  assign v_act  = (vcount >= V_ACT_LO) && (vcount <= V_ACT_HI);
  assign active = h_act && v_act;
  assign o_de   = active;

  // coordinates wrap outside the active area.
  assign scan.x           = hcount - H_ACT_LO;
  assign scan.y           = vcount - V_ACT_LO;
  assign scan.active      = active;
  assign scan.frame_start = (hcount == '0) && (vcount == '0);  // first pixel of frame.

  assign o_pix = active ? scan.color : BG;  // blank to background.

endmodule

`default_nettype wire

// ==== design/vga_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_top #(
  parameter int            H_TOTAL        = 1680,
  parameter int            V_TOTAL        = 828,
  parameter int            H_SYNC_END     = 135,
  parameter int            V_SYNC_END     = 2,
  parameter int            H_ACTIVE_START = 336,
  parameter int            H_ACTIVE_END   = 1615,
  parameter int            V_ACTIVE_START = 27,
  parameter int            V_ACTIVE_END   = 826,
  parameter vga_pkg::rgb_t BG             = '{r: 4'h0, g: 4'h0, b: 4'h0},  // blanking color.
  parameter int            BAR_SHIFT      = 7,   // 128 pixel bars.
  parameter int            CHECK_SHIFT    = 5    // 32 pixel squares.
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_wr_en,
  input  logic [vga_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [vga_pkg::REG_DATA_W-1:0] i_wr_data,
  output logic [3:0]                     o_pix_r,
  output logic [3:0]                     o_pix_g,
  output logic [3:0]                     o_pix_b,
  output logic                           o_hsync,
  output logic                           o_vsync,
  output logic                           o_de,
  output logic [vga_pkg::X_W-1:0]        o_curr_x,
  output logic [vga_pkg::Y_W-1:0]        o_curr_y
);

  import vga_pkg::*;

  pat_mode_e      mode;      // current pattern.
  rgb_t           fg;
  rgb_t           box_bg;
  logic [X_W-1:0] box_x;
  logic [X_W-1:0] box_y;
  logic [X_W-1:0] box_size;
  rgb_t           pix;       // blanked output color.

  vga_scan_if scan ();

  vga_regs u_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_en    (i_wr_en),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),  // raw word into the union.
    .o_mode     (mode),
    .o_fg       (fg),
    .o_box_bg   (box_bg),
    .o_box_x    (box_x),
    .o_box_y    (box_y),
    .o_box_size (box_size)
  );

  vga_timing #(
    .H_TOTAL        (H_TOTAL),
    .V_TOTAL        (V_TOTAL),
    .H_SYNC_END     (H_SYNC_END),
    .V_SYNC_END     (V_SYNC_END),
    .H_ACTIVE_START (H_ACTIVE_START),
    .H_ACTIVE_END   (H_ACTIVE_END),
    .V_ACTIVE_START (V_ACTIVE_START),
    .V_ACTIVE_END   (V_ACTIVE_END),
    .BG             (BG)
  ) u_timing (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .scan    (scan.timing),
    .o_hsync (o_hsync),
    .o_vsync (o_vsync),
    .o_de    (o_de),
    .o_pix   (pix)
  );

  vga_pattern #(
    .BAR_SHIFT   (BAR_SHIFT),
    .CHECK_SHIFT (CHECK_SHIFT)
  ) u_pattern (
    .scan       (scan.source),
    .i_mode     (mode),
    .i_fg       (fg),
    .i_box_bg   (box_bg),
    .i_box_x    (box_x),
    .i_box_y    (box_y),
    .i_box_size (box_size)
  );

  // split the struct onto plain pins.
  assign o_pix_r  = pix.r;
  assign o_pix_g  = pix.g;
  assign o_pix_b  = pix.b;
  assign o_curr_x = scan.x;  // same cycle as the pixel.
  assign o_curr_y = scan.y;

endmodule

`default_nettype wire

// ==== files.f ====
design/vga_pkg.sv
design/vga_scan_if.sv
design/vga_regs.sv
design/vga_timing.sv
design/vga_pattern.sv
design/vga_top.sv
verification/vga_top_props.sv
verification/tb_vga_top.sv

// ==== verification/tb_vga_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_vga_top;

  import vga_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tiny raster
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int   H_TOTAL        = 40;
  localparam int   V_TOTAL        = 24;
  localparam int   H_SYNC_END     = 3;
  localparam int   V_SYNC_END     = 1;
  localparam int   H_ACTIVE_START = 8;
  localparam int   H_ACTIVE_END   = 35;
  localparam int   V_ACTIVE_START = 3;
  localparam int   V_ACTIVE_END   = 22;
  localparam rgb_t BG             = '{r: 4'h1, g: 4'h2, b: 4'h3};
  localparam int   BAR_SHIFT      = 2;   // 4 pixel bars.
  localparam int   CHECK_SHIFT    = 2;   // 4 pixel squares.
  localparam int   H_VIS          = H_ACTIVE_END - H_ACTIVE_START + 1;  // 28 columns.
  localparam int   V_VIS          = V_ACTIVE_END - V_ACTIVE_START + 1;  // 20 lines.
  localparam int   FRAME_CYC      = H_TOTAL * V_TOTAL;
  localparam int   FRAMES_RUN     = 7;   // frames the run spans, waits included.
  localparam time  CLK_PERIOD     = 100;
  localparam time  WATCHDOG       = (FRAMES_RUN * FRAME_CYC + 200) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [REG_DATA_W-1:0] wr_data;
  logic [3:0]            pix_r;
  logic [3:0]            pix_g;
  logic [3:0]            pix_b;
  logic                  hsync;
  logic                  vsync;
  logic                  de;
  logic [X_W-1:0]        curr_x;
  logic [Y_W-1:0]        curr_y;

  pat_mode_e      m_mode;      // register copy kept by the testbench.
  rgb_t           m_fg;
  rgb_t           m_box_bg;
  logic [X_W-1:0] m_box_x;
  logic [X_W-1:0] m_box_y;
  logic [X_W-1:0] m_box_size;
  int             ref_h;       // column the raster should be on.
  int             ref_v;       // line the raster should be on.
  int             pix_errors;
  int             raster_errors;
  integer         seed;

  vga_top #(
    .H_TOTAL (H_TOTAL), .V_TOTAL (V_TOTAL), .H_SYNC_END (H_SYNC_END), .V_SYNC_END (V_SYNC_END),
    .H_ACTIVE_START (H_ACTIVE_START), .H_ACTIVE_END (H_ACTIVE_END),
    .V_ACTIVE_START (V_ACTIVE_START), .V_ACTIVE_END (V_ACTIVE_END),
    .BG (BG), .BAR_SHIFT (BAR_SHIFT), .CHECK_SHIFT (CHECK_SHIFT)
  ) u_dut (
    .i_clk (clk), .i_rst (rst), .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
    .o_pix_r (pix_r), .o_pix_g (pix_g), .o_pix_b (pix_b),
    .o_hsync (hsync), .o_vsync (vsync), .o_de (de), .o_curr_x (curr_x), .o_curr_y (curr_y)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin : raster_model
    if (rst) begin
      ref_h <= 0;
      ref_v <= 0;
    end else if (ref_h == H_TOTAL - 1) begin
      ref_h <= 0;                                       // next line.
      ref_v <= (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
    end else begin
      ref_h <= ref_h + 1;
    end
  end

  function automatic rgb_t expected_pixel(input logic [X_W-1:0] x, input logic [Y_W-1:0] y,
                                          input logic vis);
    rgb_t c;
    int   bar;
    logic in_box;
    c      = BG;                                  // blanked off screen.
    bar    = (int'(x) >> BAR_SHIFT) % 8;
    in_box = (int'(x) >= int'(m_box_x)) && (int'(x) < int'(m_box_x) + int'(m_box_size)) &&
             (int'(y) >= int'(m_box_y)) && (int'(y) < int'(m_box_y) + int'(m_box_size));
    if (vis) begin
      case (m_mode)
        PAT_SOLID:   c = m_fg;
        PAT_BARS:    c = {bar[2] ? 4'hF : 4'h0, bar[1] ? 4'hF : 4'h0, bar[0] ? 4'hF : 4'h0};
        PAT_CHECKER: c = (x[CHECK_SHIFT] ^ y[CHECK_SHIFT]) ? ~m_fg : m_fg;
        default:     c = in_box ? m_fg : m_box_bg;
      endcase
    end
    return c;
  endfunction

  task automatic update_model(input logic [REG_ADDR_W-1:0] addr, input logic [15:0] data);
    case (addr)
      ADDR_MODE:     m_mode     = pat_mode_e'(data[1:0]);  // low two bits.
      ADDR_FG:       m_fg       = data[11:0];
      ADDR_BOX_BG:   m_box_bg   = data[11:0];
      ADDR_BOX_X:    m_box_x    = data[10:0];
      ADDR_BOX_Y:    m_box_y    = data[10:0];
      ADDR_BOX_SIZE: m_box_size = data[10:0];
      default:       ;                                    // unmapped.
    endcase
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic rgb_t random_color();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  function automatic logic [15:0] color_word(input rgb_t c);
    logic [31:0] r;
    r = $random(seed);
    return {r[3:0], c};        // spare bits are noise.
  endfunction

  function automatic logic [15:0] coord_word(input int value);
    logic [31:0] r;
    r = $random(seed);
    return {r[4:0], value[10:0]};
  endfunction

  function automatic logic [15:0] mode_word(input pat_mode_e m);
    logic [31:0] r;
    r = $random(seed);
    return {r[13:0], m};
  endfunction

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [15:0] data);
    @(posedge clk);
    #5;
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);            // dut takes the word here.
    update_model(addr, data);
    #5;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
  endtask

  task automatic run_frames(input int n);
    repeat (n * FRAME_CYC) @(posedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin : output_check
    rgb_t           exp_pix;
    rgb_t           got_pix;
    logic           exp_de;
    logic           exp_hs;
    logic           exp_vs;
    logic [X_W-1:0] exp_x;
    logic [Y_W-1:0] exp_y;
    logic [X_W-1:0] h_cnt;
    logic [Y_W-1:0] v_cnt;
    got_pix = {pix_r, pix_g, pix_b};
    exp_x   = X_W'(ref_h - H_ACTIVE_START);             // wraps before the active start.
    exp_y   = Y_W'(ref_v - V_ACTIVE_START);
    h_cnt   = curr_x + X_W'(H_ACTIVE_START);              // counters behind the coordinates.
    v_cnt   = curr_y + Y_W'(V_ACTIVE_START);
    exp_hs  = int'(h_cnt) > H_SYNC_END;
    exp_vs  = int'(v_cnt) > V_SYNC_END;
    exp_de  = (int'(curr_x) < H_VIS) && (int'(curr_y) < V_VIS);
    exp_pix = expected_pixel(curr_x, curr_y, exp_de);
    assert (curr_x === exp_x) else begin
      $display("[FAIL] %0t ns o_curr_x expected %0d got %0d", $time, exp_x, curr_x);
      raster_errors++;
    end
    assert (curr_y === exp_y) else begin
      $display("[FAIL] %0t ns o_curr_y expected %0d got %0d", $time, exp_y, curr_y);
      raster_errors++;
    end
    assert (de === exp_de) else begin
      $display("[FAIL] %0t ns o_de expected %b got %b", $time, exp_de, de);
      raster_errors++;
    end
    assert (hsync === exp_hs) else begin
      $display("[FAIL] %0t ns o_hsync expected %b got %b", $time, exp_hs, hsync);
      raster_errors++;
    end
    assert (vsync === exp_vs) else begin
      $display("[FAIL] %0t ns o_vsync expected %b got %b", $time, exp_vs, vsync);
      raster_errors++;
    end
    assert (got_pix === exp_pix) else begin
      $display("[FAIL] %0t ns o_pix expected %h got %h", $time, exp_pix, got_pix);
      pix_errors++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG);
    $display("watchdog expired after %0t ns with the sequence unfinished", $time);
    $display("Test FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    rgb_t new_fg;
    int   total;
    rst           = 1'b1;
    wr_en         = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    seed          = 32'h151d_cd32;
    pix_errors    = 0;
    raster_errors = 0;
    m_mode        = PAT_SOLID;    // reset contents.
    m_fg          = 12'hFFF;
    m_box_bg      = 12'h000;
    m_box_x       = '0;
    m_box_y       = '0;
    m_box_size    = X_W'(8);
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    run_frames(2);                // solid white over two rasters.

    write_reg(ADDR_FG, color_word(random_color()));
    write_reg(ADDR_MODE, mode_word(PAT_BARS));
    run_frames(1);
    write_reg(ADDR_MODE, mode_word(PAT_CHECKER));
    run_frames(1);

    write_reg(ADDR_BOX_BG, color_word(random_color()));
    write_reg(ADDR_BOX_X, coord_word($unsigned($random(seed)) % H_VIS));
    write_reg(ADDR_BOX_Y, coord_word($unsigned($random(seed)) % V_VIS));
    write_reg(ADDR_BOX_SIZE, coord_word(1 + $unsigned($random(seed)) % 12));
    write_reg(ADDR_MODE, mode_word(PAT_BOX));
    run_frames(1);
    write_reg(3'd6, 16'($random(seed)));   // must not land anywhere.
    write_reg(3'd7, 16'($random(seed)));
    run_frames(1);

    // foreground change in the middle of a visible line.
    write_reg(ADDR_MODE, mode_word(PAT_SOLID));
    do @(negedge clk); while (!(de && curr_x < 10));
    new_fg = random_color();
    if (new_fg == m_fg) begin
      new_fg = ~new_fg;
    end
    write_reg(ADDR_FG, color_word(new_fg));
    @(negedge clk);
    assert ({pix_r, pix_g, pix_b} === new_fg) else begin
      $display("[FAIL] %0t ns o_pix expected %h got %h", $time, new_fg, {pix_r, pix_g, pix_b});
      pix_errors++;
    end
    repeat (H_TOTAL) @(posedge clk);

    total = pix_errors + raster_errors + u_dut.u_props.fail_count;
    $display("errors: pixel %0d, raster %0d, bound assertions %0d",
             pix_errors, raster_errors, u_dut.u_props.fail_count);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/vga_top_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_top_props #(
  parameter int H_TOTAL        = 1680,
  parameter int H_SYNC_END     = 135,
  parameter int H_ACTIVE_START = 336
) (
  input logic                    i_clk,
  input logic                    i_rst,
  input logic                    i_hsync,
  input logic                    i_vsync,
  input logic                    i_de,
  input logic [vga_pkg::X_W-1:0] i_curr_x
);

  import vga_pkg::*;

  logic [X_W-1:0] h_implied;   // column counter behind x.
  logic           hsync_q;     // hsync one cycle back.
  logic           hsync_rise;
  logic           seen_rise;   // first rise already passed.
  logic [15:0]    since_rise;  // cycles since last rise.
  int             fail_count = 0;

  assign h_implied  = i_curr_x + X_W'(H_ACTIVE_START);  // undo the active offset.
  assign hsync_rise = i_hsync && !hsync_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      hsync_q    <= 1'b0;
      seen_rise  <= 1'b0;
      since_rise <= '0;
    end else begin
      hsync_q <= i_hsync;
      if (hsync_rise) begin
        seen_rise  <= 1'b1;
        since_rise <= 16'd1;              // restart the line period.
      end else begin
        since_rise <= since_rise + 16'd1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // timing properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  hsync_rule: assert property (@(posedge i_clk) disable iff (i_rst)
    i_hsync == (h_implied > X_W'(H_SYNC_END)))
  else begin
    fail_count++;
    $error("hsync does not follow the column count behind o_curr_x");
  end

  de_in_sync: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_de && (!i_hsync || !i_vsync)))
  else begin
    fail_count++;
    $error("display enable high while a sync pulse is low");
  end

  hsync_period: assert property (@(posedge i_clk) disable iff (i_rst)
    (hsync_rise && seen_rise) |-> (since_rise == 16'(H_TOTAL)))
  else begin
    fail_count++;
    $error("hsync rising edges are not one line period apart");
  end

endmodule

bind vga_top vga_top_props #(
  .H_TOTAL        (H_TOTAL),
  .H_SYNC_END     (H_SYNC_END),
  .H_ACTIVE_START (H_ACTIVE_START)
) u_props (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_hsync  (o_hsync),
  .i_vsync  (o_vsync),
  .i_de     (o_de),
  .i_curr_x (o_curr_x)
);

`default_nettype wire
